//--- stap_top.f
stap_pkg.sv
stap_ctrl_if.sv
stap_fsm.sv
stap_irreg.sv
stap_drreg.sv
stap_wtapnw.sv
stap_tdomux.sv
stap_top.sv
tb_stap_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sTAP testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f stap_top.f --top-module tb_stap_top -o tb_stap_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_stap_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" sim.log; then
   exit 1
fi
exit 0

//--- tb_stap_top.sv
`timescale 1ns/10ps

module tb_stap_top;

   import stap_pkg::*;

   // Scans need a few hundred cycles, generous margin on top
   localparam int MAX_CYCLES = 3000;

   logic                           tck;
   logic                           rst_n;
   logic                           tms;
   logic                           tdi;
   logic                           atap_tdo;
   logic                           atap_tdoen;
   logic [STAP_NUM_WTAPS-1:0]      wsi;
   logic                           selectwir;
   logic                           capturewr;
   logic                           shiftwr;
   logic                           updatewr;
   logic [STAP_NUM_WTAPS-1:0]      wso;
   logic [STAP_TAPC_SEL_WIDTH-1:0] tapc_sel;
   // Wrapper model chains
   logic [5:0]                     wtap_q [STAP_NUM_WTAPS];
   logic [31:0]                    lfsr;
   // wsi bits that must stay high while shifting
   logic [STAP_NUM_WTAPS-1:0]      park;
   int                             value_errs;
   int                             other_errs;
   int                             cycles;

   stap_top stap_top_inst (.ftap_tck(tck), .rst_n(rst_n), .ftap_tms(tms), .ftap_tdi(tdi),
      .atap_tdo(atap_tdo), .atap_tdoen(atap_tdoen), .sn_fwtap_wsi(wsi),
      .sn_fwtap_selectwir(selectwir), .sn_fwtap_capturewr(capturewr),
      .sn_fwtap_shiftwr(shiftwr), .sn_fwtap_updatewr(updatewr), .sn_awtap_wso(wso),
      .stap_tapc_select(tapc_sel));

   initial
   begin
      tck = 1'b0;
      forever #2 tck = ~tck;
   end

   // ********************************************************
   // WTAP models, 6-bit chains moving on shiftwr
   // ********************************************************
   always @(posedge tck or negedge rst_n)
   begin
      for (int k = 0; k < STAP_NUM_WTAPS; k++)
      begin
         if (!rst_n)
            wtap_q[k] <= '0;
         else if (shiftwr)
            wtap_q[k] <= {wsi[k], wtap_q[k][5:1]};
      end
   end

   // Quiet return path while reset is held
   always_comb
   begin
      for (int k = 0; k < STAP_NUM_WTAPS; k++)
         wso[k] = (rst_n === 1'b1) ? wtap_q[k][0] : 1'b0;
   end

   task automatic compare(input string name, input logic [63:0] exp_v,
                          input logic [63:0] act_v);
      assert (act_v === exp_v)
      else
      begin
         value_errs++;
         $display("error %s expected %h actual %h", name, exp_v, act_v);
      end
   endtask

   // Galois LFSR, one step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
         r[i] = lfsr[0];
      end
      return r;
   endfunction

   // Highest selected wrapper, -1 if none
   function automatic int winner(input logic [STAP_NUM_WTAPS-1:0] sel);
      int w;
      w = -1;
      for (int k = 0; k < STAP_NUM_WTAPS; k++)
         if (sel[k])
            w = k;
      return w;
   endfunction

   // ********************************************************
   // TCK cycle and scan sequences
   // ********************************************************
   // Drive, then sample TDO as it stood at the rising edge
   task automatic clock_bit(input logic tms_v, input logic tdi_v, input logic exp_en,
                            input logic exp_wir, output logic tdo_v);
      tms = tms_v;
      tdi = tdi_v;
      @(posedge tck);
      #0.5;
      tdo_v = atap_tdo;
      // Enable shows the state before the edge
      compare("atap_tdoen", 64'(exp_en), 64'(atap_tdoen));
      compare("sn_fwtap_selectwir", 64'(exp_wir), 64'(selectwir));
      if (exp_en)
         compare("sn_fwtap_wsi", 64'(park), 64'(wsi & park));
   endtask

   // One column from Run-Test/Idle and back, LSB first
   task automatic shift_column(input logic ir, input int n, input logic [63:0] din,
                               output logic [63:0] dout);
      logic b;
      dout = '0;
      clock_bit(1'b1, 1'b0, 1'b0, 1'b0, b);
      if (ir)
         clock_bit(1'b1, 1'b0, 1'b0, 1'b1, b);
      clock_bit(1'b0, 1'b0, 1'b0, ir, b);
      // Capture state of either column
      compare("sn_fwtap_capturewr", 64'h1, 64'(capturewr));
      clock_bit(1'b0, 1'b0, 1'b0, ir, b);
      // Now in the shift state
      compare("sn_fwtap_capturewr", 64'h0, 64'(capturewr));
      compare("sn_fwtap_shiftwr", 64'h1, 64'(shiftwr));
      for (int i = 0; i < n; i++)
      begin
         clock_bit(i == n - 1, din[i], 1'b1, ir, b);
         dout[i] = b;
      end
      clock_bit(1'b1, 1'b0, 1'b0, ir, b);
      // Update state of either column
      compare("sn_fwtap_updatewr", 64'h1, 64'(updatewr));
      clock_bit(1'b0, 1'b0, 1'b0, 1'b0, b);
      compare("sn_fwtap_updatewr", 64'h0, 64'(updatewr));
      compare("sn_fwtap_shiftwr", 64'h0, 64'(shiftwr));
   endtask

   task automatic scan_dr(input int n, input logic [63:0] din, output logic [63:0] dout);
      shift_column(1'b0, n, din, dout);
   endtask

   task automatic scan_ir(input int n, input logic [63:0] din, output logic [63:0] dout);
      shift_column(1'b1, n, din, dout);
   endtask

   // Five TMS-high clocks out of Shift-DR, then idle
   task automatic reset_tms(output logic [4:0] dout);
      logic b;
      for (int k = 0; k < 5; k++)
      begin
         // Fourth clock lands in Select-IR-Scan
         clock_bit(1'b1, 1'b0, k == 0, k == 3, b);
         dout[k] = b;
      end
      clock_bit(1'b0, 1'b0, 1'b0, 1'b0, b);
   endtask

   task automatic load_ir(input logic [STAP_IR_WIDTH-1:0] opc);
      logic [63:0] dout;
      scan_ir(STAP_IR_WIDTH, 64'(opc), dout);
      compare("atap_tdo ir capture", 64'(STAP_IR_CAPTURE), 64'(dout[STAP_IR_WIDTH-1:0]));
   endtask

   // Data comes back one bit late behind a captured 0
   task automatic bypass_delay_test();
      logic [63:0] din;
      logic [63:0] dout;
      din = rand_bits(40);
      scan_dr(40, din, dout);
      compare("atap_tdo bypass", {24'h0, din[38:0], 1'b0}, dout);
   endtask

   // Write the select register, then scan the 4 + 6 bit chain
   task automatic select_and_scan(input logic [STAP_NWSEL_WIDTH-1:0] sel);
      logic [63:0] din;
      logic [63:0] dout;
      logic [19:0] stream;
      logic [5:0]  snap;
      int          w;
      scan_dr(STAP_NWSEL_WIDTH, 64'(sel), dout);
      w = winner(sel[STAP_NUM_WTAPS-1:0]);
      park = '1;
      if (sel[STAP_NWSEL_WIDTH-1:STAP_NUM_WTAPS] == '0)
         park[w] = 1'b0;
      // Last four bits rewrite the same selection
      din = rand_bits(20);
      din[19:16] = sel;
      // Bits the winner sees on wsi, all high under a child TAP select
      stream = (park == '1) ? '1 : {din[15:0], sel};
      snap = wtap_q[w];
      scan_dr(20, din, dout);
      compare("atap_tdo chain", 64'({stream[13:0], snap}), dout);
      compare("wtap model", 64'(stream[19:14]), 64'(wtap_q[w]));
      for (int k = 0; k < STAP_NUM_WTAPS; k++)
         if (k != w)
            compare("parked wtap model", 64'h3F, 64'(wtap_q[k]));
      compare("stap_tapc_select", 64'(sel[STAP_NWSEL_WIDTH-1:STAP_NUM_WTAPS]), 64'(tapc_sel));
   endtask

   // ********************************************************
   // Test sequence
   // ********************************************************
   initial
   begin
      logic [63:0] dout;
      logic [4:0]  rbits;
      logic [5:0]  snap;
      logic        b;
      value_errs = 0;
      lfsr = 32'h006f_0fb0;
      park = '1;
      rst_n = 1'b0;
      tms = 1'b1;
      tdi = 1'b0;
      repeat (8) @(posedge tck);
      #0.5;
      rst_n = 1'b1;

      compare("atap_tdoen", 64'h0, 64'(atap_tdoen));
      compare("sn_fwtap_wsi", 64'(park), 64'(wsi));
      compare("stap_tapc_select", 64'h0, 64'(tapc_sel));
      clock_bit(1'b0, 1'b0, 1'b0, 1'b0, b);
      // IDCODE is the instruction out of reset
      scan_dr(32, rand_bits(32), dout);
      compare("atap_tdo idcode", 64'(STAP_IDCODE), 64'(dout[31:0]));

      load_ir(STAP_OPC_BYPASS);
      bypass_delay_test();
      // Undefined opcode
      load_ir(8'h5A);
      bypass_delay_test();

      load_ir(STAP_OPC_NWSEL);
      select_and_scan(4'b0001);
      select_and_scan(4'b0011);
      select_and_scan(4'b0010);
      // Child TAP field set on top of both wrappers
      select_and_scan(4'b0111);

      // Into Shift-DR, then out through Test-Logic-Reset
      clock_bit(1'b1, 1'b0, 1'b0, 1'b0, b);
      clock_bit(1'b0, 1'b0, 1'b0, 1'b0, b);
      clock_bit(1'b0, 1'b0, 1'b0, 1'b0, b);
      snap = wtap_q[1];
      reset_tms(rbits);
      compare("atap_tdo leaving shift", 64'(snap[0]), 64'(rbits[0]));
      park = '1;
      compare("sn_fwtap_wsi", 64'(park), 64'(wsi));
      compare("stap_tapc_select", 64'h0, 64'(tapc_sel));
      scan_dr(32, rand_bits(32), dout);
      compare("atap_tdo idcode after tlr", 64'(STAP_IDCODE), 64'(dout[31:0]));

      $display("errors: value %0d, other %0d", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Cycle limit against a stuck sequence
   initial
   begin
      cycles = 0;
      other_errs = 0;
      while (cycles < MAX_CYCLES)
      begin
         @(posedge tck);
         cycles++;
      end
      other_errs++;
      $display("timeout, scan sequence still running after %0d cycles", cycles);
      $display("errors: value %0d, other %0d", value_errs, other_errs);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- stap_top.sv
`timescale 1ns/10ps

module stap_top
(
   input  logic                                     ftap_tck,
   input  logic                                     rst_n,
   input  logic                                     ftap_tms,
   input  logic                                     ftap_tdi,
   output logic                                     atap_tdo,
   output logic                                     atap_tdoen,
   // Wrapper TAP side
   output logic [stap_pkg::STAP_NUM_WTAPS-1:0]      sn_fwtap_wsi,
   output logic                                     sn_fwtap_selectwir,
   output logic                                     sn_fwtap_capturewr,
   output logic                                     sn_fwtap_shiftwr,
   output logic                                     sn_fwtap_updatewr,
   input  logic [stap_pkg::STAP_NUM_WTAPS-1:0]      sn_awtap_wso,
   // Child TAP select field
   output logic [stap_pkg::STAP_TAPC_SEL_WIDTH-1:0] stap_tapc_select
);

   import stap_pkg::*;

   logic                           ir_tdo;
   logic                           dr_tdo;
   logic                           sel_bypass;
   logic                           sel_idcode;
   logic                           sel_nwsel;
   logic [STAP_NUM_WTAPS-1:0]      tapc_wtap_sel;
   logic [STAP_TAPC_SEL_WIDTH-1:0] tapc_select;
   logic                           stap_mux_tdo;
   logic                           stap_wtapnw_tdo;

   stap_ctrl_if ctrl ();

   // ********************************************************
   // Controller and registers
   // ********************************************************
   stap_fsm stap_fsm_inst (.ftap_tck(ftap_tck), .rst_n(rst_n), .ftap_tms(ftap_tms), .ctrl(ctrl));

   stap_irreg stap_irreg_inst (.ftap_tck(ftap_tck), .rst_n(rst_n), .ftap_tdi(ftap_tdi),
      .ctrl(ctrl), .ir_tdo(ir_tdo), .sel_bypass(sel_bypass), .sel_idcode(sel_idcode),
      .sel_nwsel(sel_nwsel));

   stap_drreg stap_drreg_inst (.ftap_tck(ftap_tck), .rst_n(rst_n), .ftap_tdi(ftap_tdi),
      .ctrl(ctrl), .sel_bypass(sel_bypass), .sel_idcode(sel_idcode), .sel_nwsel(sel_nwsel),
      .dr_tdo(dr_tdo), .tapc_wtap_sel(tapc_wtap_sel), .tapc_select(tapc_select));

   // ********************************************************
   // Serial path out, through the wrapper network
   // ********************************************************
   stap_wtapnw stap_wtapnw_inst (.stap_mux_tdo(stap_mux_tdo), .stap_selectwir(ctrl.ir_path),
      .sn_awtap_wso(sn_awtap_wso), .tapc_wtap_sel(tapc_wtap_sel), .tapc_select(tapc_select),
      .sn_fwtap_selectwir(sn_fwtap_selectwir), .sn_fwtap_wsi(sn_fwtap_wsi),
      .stap_wtapnw_tdo(stap_wtapnw_tdo));

   stap_tdomux stap_tdomux_inst (.ftap_tck(ftap_tck), .rst_n(rst_n), .ctrl(ctrl),
      .ir_tdo(ir_tdo), .dr_tdo(dr_tdo), .stap_wtapnw_tdo(stap_wtapnw_tdo),
      .tapc_wtap_sel(tapc_wtap_sel), .stap_mux_tdo(stap_mux_tdo), .atap_tdo(atap_tdo),
      .atap_tdoen(atap_tdoen));

   // Wrapper strobes follow both columns
   assign sn_fwtap_capturewr = ctrl.capture_dr | ctrl.capture_ir;
   assign sn_fwtap_shiftwr   = ctrl.shift_dr | ctrl.shift_ir;
   assign sn_fwtap_updatewr  = ctrl.update_dr | ctrl.update_ir;

   assign stap_tapc_select   = tapc_select;

endmodule

//--- stap_tdomux.sv
`timescale 1ns/10ps

module stap_tdomux
(
   input  logic                                ftap_tck,
   input  logic                                rst_n,
   stap_ctrl_if.tdomux                         ctrl,
   input  logic                                ir_tdo,
   input  logic                                dr_tdo,
   input  logic                                stap_wtapnw_tdo,
   input  logic [stap_pkg::STAP_NUM_WTAPS-1:0] tapc_wtap_sel,
   output logic                                stap_mux_tdo,
   output logic                                atap_tdo,
   output logic                                atap_tdoen
);

   logic tdo_pre;

   // IR column uses the instruction register
   assign stap_mux_tdo = ctrl.ir_path ? ir_tdo : dr_tdo;

   // Any selected WTAP extends the chain
   assign tdo_pre = (|tapc_wtap_sel) ? stap_wtapnw_tdo : stap_mux_tdo;

   // ********************************************************
   // Falling-edge output stage
   // ********************************************************
   always_ff @(negedge ftap_tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         atap_tdo   <= 1'b0;
         atap_tdoen <= 1'b0;
      end
      else
      begin
         atap_tdo   <= tdo_pre;
         atap_tdoen <= ctrl.shift_dr | ctrl.shift_ir;
      end
   end

endmodule

//--- stap_wtapnw.sv
`timescale 1ns/10ps

module stap_wtapnw
(
   input  logic                                     stap_mux_tdo,
   input  logic                                     stap_selectwir,
   input  logic [stap_pkg::STAP_NUM_WTAPS-1:0]      sn_awtap_wso,
   input  logic [stap_pkg::STAP_NUM_WTAPS-1:0]      tapc_wtap_sel,
   input  logic [stap_pkg::STAP_TAPC_SEL_WIDTH-1:0] tapc_select,
   output logic                                     sn_fwtap_selectwir,
   output logic [stap_pkg::STAP_NUM_WTAPS-1:0]      sn_fwtap_wsi,
   output logic                                     stap_wtapnw_tdo
);

   import stap_pkg::*;

   logic [STAP_NUM_WTAPS-1:0] wtap_win;

   // WIR select goes straight to every wrapper
   assign sn_fwtap_selectwir = stap_selectwir;

   // ********************************************************
   // Priority pick, highest selected index wins
   // ********************************************************
   always_comb
   begin
      wtap_win = '0;
      for (int i = 0; i < STAP_NUM_WTAPS; i++)
      begin
         // Later hits overwrite earlier ones
         if (tapc_wtap_sel[i])
         begin
            wtap_win    = '0;
            wtap_win[i] = 1'b1;
         end
      end
   end

   // ********************************************************
   // Forward path to wrapper serial inputs
   // ********************************************************
   always_comb
   begin
      sn_fwtap_wsi = '1;
      // Child TAP select or no WTAP parks every wsi high
      if (!(|tapc_select) && (|tapc_wtap_sel))
      begin
         for (int j = 0; j < STAP_NUM_WTAPS; j++)
         begin
            if (wtap_win[j])
               sn_fwtap_wsi[j] = stap_mux_tdo;
         end
      end
   end

   // Return path, winner only
   assign stap_wtapnw_tdo = |(wtap_win & tapc_wtap_sel & sn_awtap_wso);

endmodule

//--- stap_drreg.sv
`timescale 1ns/10ps

module stap_drreg
(
   input  logic                                        ftap_tck,
   input  logic                                        rst_n,
   input  logic                                        ftap_tdi,
   stap_ctrl_if.drreg                                  ctrl,
   input  logic                                        sel_bypass,
   input  logic                                        sel_idcode,
   input  logic                                        sel_nwsel,
   output logic                                        dr_tdo,
   output logic [stap_pkg::STAP_NUM_WTAPS-1:0]         tapc_wtap_sel,
   output logic [stap_pkg::STAP_TAPC_SEL_WIDTH-1:0]    tapc_select
);

   import stap_pkg::*;

   logic                         bypass_reg;
   logic [STAP_IDCODE_WIDTH-1:0] idcode_shift;
   logic [STAP_NWSEL_WIDTH-1:0]  nwsel_shift;
   logic [STAP_NWSEL_WIDTH-1:0]  nwsel_upd;

   // ********************************************************
   // Shift stages, only the selected one moves
   // ********************************************************
   always_ff @(posedge ftap_tck)
   begin
      // Bypass captures a 0
      if (ctrl.capture_dr && sel_bypass)
         bypass_reg <= 1'b0;
      else if (ctrl.shift_dr && sel_bypass)
         bypass_reg <= ftap_tdi;

      if (ctrl.capture_dr && sel_idcode)
         idcode_shift <= STAP_IDCODE;
      else if (ctrl.shift_dr && sel_idcode)
         idcode_shift <= {ftap_tdi, idcode_shift[STAP_IDCODE_WIDTH-1:1]};

      // Readback of the live selection
      if (ctrl.capture_dr && sel_nwsel)
         nwsel_shift <= nwsel_upd;
      else if (ctrl.shift_dr && sel_nwsel)
         nwsel_shift <= {ftap_tdi, nwsel_shift[STAP_NWSEL_WIDTH-1:1]};
   end

   // ********************************************************
   // Network select update stage
   // ********************************************************
   always_ff @(negedge ftap_tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         nwsel_upd <= '0;
      end
      else if (ctrl.tlr)
      begin
         nwsel_upd <= '0;
      end
      else if (ctrl.update_dr && sel_nwsel)
      begin
         nwsel_upd <= nwsel_shift;
      end
   end

   // WTAP selects in the low bits
   assign tapc_wtap_sel = nwsel_upd[STAP_NUM_WTAPS-1:0];
   assign tapc_select   = nwsel_upd[STAP_NWSEL_WIDTH-1:STAP_NUM_WTAPS];

   // Serial out of the selected register
   assign dr_tdo = sel_idcode ? idcode_shift[0] :
                   sel_nwsel  ? nwsel_shift[0]  :
                                bypass_reg;

endmodule

//--- stap_irreg.sv
`timescale 1ns/10ps

module stap_irreg
(
   input  logic       ftap_tck,
   input  logic       rst_n,
   input  logic       ftap_tdi,
   stap_ctrl_if.irreg ctrl,
   output logic       ir_tdo,
   output logic       sel_bypass,
   output logic       sel_idcode,
   output logic       sel_nwsel
);

   import stap_pkg::*;

   logic [STAP_IR_WIDTH-1:0] ir_shift;
   logic [STAP_IR_WIDTH-1:0] ir_upd;

   // ********************************************************
   // Shift stage
   // ********************************************************
   always_ff @(posedge ftap_tck)
   begin
      if (ctrl.capture_ir)
      begin
         ir_shift <= STAP_IR_CAPTURE;
      end
      else if (ctrl.shift_ir)
      begin
         // TDI in at the top, LSB leaves first
         ir_shift <= {ftap_tdi, ir_shift[STAP_IR_WIDTH-1:1]};
      end
   end

   assign ir_tdo = ir_shift[0];

   // ********************************************************
   // Update stage, falling edge
   // ********************************************************
   always_ff @(negedge ftap_tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ir_upd <= STAP_OPC_IDCODE;
      end
      else if (ctrl.tlr)
      begin
         // Back to IDCODE whenever TLR is entered
         ir_upd <= STAP_OPC_IDCODE;
      end
      else if (ctrl.update_ir)
      begin
         ir_upd <= ir_shift;
      end
   end

   // Opcode decode, one-hot selects
   always_comb
   begin
      sel_bypass = 1'b0;
      sel_idcode = 1'b0;
      sel_nwsel  = 1'b0;
      case (ir_upd)
         STAP_OPC_IDCODE: sel_idcode = 1'b1;
         STAP_OPC_NWSEL:  sel_nwsel  = 1'b1;
         STAP_OPC_BYPASS: sel_bypass = 1'b1;
         // Undefined opcodes fall back to bypass
         default:         sel_bypass = 1'b1;
      endcase
   end

endmodule

//--- stap_fsm.sv
`timescale 1ns/10ps

module stap_fsm
(
   input  logic     ftap_tck,
   input  logic     rst_n,
   input  logic     ftap_tms,
   stap_ctrl_if.fsm ctrl
);

   import stap_pkg::*;

   logic [3:0] state;
   logic [3:0] state_nxt;

   // ********************************************************
   // State register
   // ********************************************************
   always_ff @(posedge ftap_tck or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= STAP_ST_TLR;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // ********************************************************
   // Next-state table, TMS steers every arc
   // ********************************************************
   always_comb
   begin
      case (state)
         // Stays in reset while TMS high
         STAP_ST_TLR:       state_nxt = ftap_tms ? STAP_ST_TLR       : STAP_ST_RTI;
         STAP_ST_RTI:       state_nxt = ftap_tms ? STAP_ST_SEL_DR    : STAP_ST_RTI;
         // DR column
         STAP_ST_SEL_DR:    state_nxt = ftap_tms ? STAP_ST_SEL_IR    : STAP_ST_CAP_DR;
         STAP_ST_CAP_DR:    state_nxt = ftap_tms ? STAP_ST_EXIT1_DR  : STAP_ST_SHIFT_DR;
         STAP_ST_SHIFT_DR:  state_nxt = ftap_tms ? STAP_ST_EXIT1_DR  : STAP_ST_SHIFT_DR;
         STAP_ST_EXIT1_DR:  state_nxt = ftap_tms ? STAP_ST_UPDATE_DR : STAP_ST_PAUSE_DR;
         STAP_ST_PAUSE_DR:  state_nxt = ftap_tms ? STAP_ST_EXIT2_DR  : STAP_ST_PAUSE_DR;
         STAP_ST_EXIT2_DR:  state_nxt = ftap_tms ? STAP_ST_UPDATE_DR : STAP_ST_SHIFT_DR;
         STAP_ST_UPDATE_DR: state_nxt = ftap_tms ? STAP_ST_SEL_DR    : STAP_ST_RTI;
         // IR column, escape to reset from select
         STAP_ST_SEL_IR:    state_nxt = ftap_tms ? STAP_ST_TLR       : STAP_ST_CAP_IR;
         STAP_ST_CAP_IR:    state_nxt = ftap_tms ? STAP_ST_EXIT1_IR  : STAP_ST_SHIFT_IR;
         STAP_ST_SHIFT_IR:  state_nxt = ftap_tms ? STAP_ST_EXIT1_IR  : STAP_ST_SHIFT_IR;
         STAP_ST_EXIT1_IR:  state_nxt = ftap_tms ? STAP_ST_UPDATE_IR : STAP_ST_PAUSE_IR;
         STAP_ST_PAUSE_IR:  state_nxt = ftap_tms ? STAP_ST_EXIT2_IR  : STAP_ST_PAUSE_IR;
         STAP_ST_EXIT2_IR:  state_nxt = ftap_tms ? STAP_ST_UPDATE_IR : STAP_ST_SHIFT_IR;
         STAP_ST_UPDATE_IR: state_nxt = ftap_tms ? STAP_ST_SEL_DR    : STAP_ST_RTI;
         default:           state_nxt = STAP_ST_TLR;
      endcase
   end

   // ********************************************************
   // Strobe decode, purely from current state
   // ********************************************************
   assign ctrl.capture_dr = (state == STAP_ST_CAP_DR);
   assign ctrl.shift_dr   = (state == STAP_ST_SHIFT_DR);
   assign ctrl.update_dr  = (state == STAP_ST_UPDATE_DR);

   assign ctrl.capture_ir = (state == STAP_ST_CAP_IR);
   assign ctrl.shift_ir   = (state == STAP_ST_SHIFT_IR);
   assign ctrl.update_ir  = (state == STAP_ST_UPDATE_IR);

   assign ctrl.tlr        = (state == STAP_ST_TLR);

   // Whole IR column, including its select state
   assign ctrl.ir_path    = (state == STAP_ST_SEL_IR)    ||
                            (state == STAP_ST_CAP_IR)    ||
                            (state == STAP_ST_SHIFT_IR)  ||
                            (state == STAP_ST_EXIT1_IR)  ||
                            (state == STAP_ST_PAUSE_IR)  ||
                            (state == STAP_ST_EXIT2_IR)  ||
                            (state == STAP_ST_UPDATE_IR);

endmodule

//--- stap_ctrl_if.sv
`timescale 1ns/10ps

interface stap_ctrl_if;

   // DR column strobes
   logic capture_dr;
   logic shift_dr;
   logic update_dr;

   // IR column strobes
   logic capture_ir;
   logic shift_ir;
   logic update_ir;

   // Test-Logic-Reset state
   logic tlr;
   // Select-IR-Scan through Update-IR
   logic ir_path;

   modport fsm (output capture_dr, shift_dr, update_dr,
                output capture_ir, shift_ir, update_ir,
                output tlr, ir_path);

   modport irreg (input capture_ir, shift_ir, update_ir, tlr);

   modport drreg (input capture_dr, shift_dr, update_dr, tlr);

   modport tdomux (input shift_dr, shift_ir, ir_path);

endinterface

//--- stap_pkg.sv
package stap_pkg;

   // ********************************************************
   // Register widths
   // ********************************************************
   localparam int STAP_IR_WIDTH       = 8;
   localparam int STAP_NUM_WTAPS      = 2;
   localparam int STAP_NUM_TAPS       = 1;
   // Two select bits for each child TAP
   localparam int STAP_TAPC_SEL_WIDTH = 2 * STAP_NUM_TAPS;
   // WTAP selects low, child-TAP select field high
   localparam int STAP_NWSEL_WIDTH    = STAP_TAPC_SEL_WIDTH + STAP_NUM_WTAPS;
   localparam int STAP_IDCODE_WIDTH   = 32;

   // ********************************************************
   // Instruction opcodes
   // ********************************************************
   localparam logic [STAP_IR_WIDTH-1:0] STAP_OPC_BYPASS = 8'hFF;
   localparam logic [STAP_IR_WIDTH-1:0] STAP_OPC_IDCODE = 8'h0C;
   localparam logic [STAP_IR_WIDTH-1:0] STAP_OPC_NWSEL  = 8'h12;

   // Fixed pattern seen on TDO at the start of every IR scan
   localparam logic [STAP_IR_WIDTH-1:0] STAP_IR_CAPTURE = 8'h01;

   // Device identification, bit 0 set as 1149.1 demands
   localparam logic [STAP_IDCODE_WIDTH-1:0] STAP_IDCODE = 32'h0B5A_E013;

   // ********************************************************
   // TAP controller state encoding
   // ********************************************************
   localparam logic [3:0] STAP_ST_TLR       = 4'hF;
   localparam logic [3:0] STAP_ST_RTI       = 4'hC;
   localparam logic [3:0] STAP_ST_SEL_DR    = 4'h7;
   localparam logic [3:0] STAP_ST_CAP_DR    = 4'h6;
   localparam logic [3:0] STAP_ST_SHIFT_DR  = 4'h2;
   localparam logic [3:0] STAP_ST_EXIT1_DR  = 4'h1;
   localparam logic [3:0] STAP_ST_PAUSE_DR  = 4'h3;
   localparam logic [3:0] STAP_ST_EXIT2_DR  = 4'h0;
   localparam logic [3:0] STAP_ST_UPDATE_DR = 4'h5;
   localparam logic [3:0] STAP_ST_SEL_IR    = 4'h4;
   localparam logic [3:0] STAP_ST_CAP_IR    = 4'hE;
   localparam logic [3:0] STAP_ST_SHIFT_IR  = 4'hA;
   localparam logic [3:0] STAP_ST_EXIT1_IR  = 4'h9;
   localparam logic [3:0] STAP_ST_PAUSE_IR  = 4'hB;
   localparam logic [3:0] STAP_ST_EXIT2_IR  = 4'h8;
   localparam logic [3:0] STAP_ST_UPDATE_IR = 4'hD;

endpackage
